//--- Makefile
VERILATOR ?= verilator
TOP ?= fp_mul_unit_tb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing
PASS_MSG ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- compile.f
+incdir+source
source/fp_format_pkg.sv
source/fp_round_pkg.sv
source/fp_unpack.sv
source/float_multiplier.sv
source/fp_round_pack.sv
source/fp_mul_unit.sv
testbench/fp_mul_unit_tb.sv

//--- source/float_multiplier.sv
`timescale 1ns/1ns

`include "fp_config.svh"

module float_multiplier
	import fp_format_pkg::*;
	import fp_round_pkg::*;
(
	input	logic			clk,
	input	logic			reset,

	input	logic			valid_in,
	output	logic			ready_out,
	output	logic			valid_out,
	input	logic			ready_in,

	input	fp_rm_t			rm,
	input	fp_operand_t	a,
	input	fp_operand_t	b,

	output	fp_product_t	product
);

	localparam int MAN_LEN	= `FP_MAN_W + 1;
	localparam int RES_W	= 2 * MAN_LEN;
	localparam int ACC_W	= MAN_LEN + `FP_STEP;
	localparam int STEPS	= MAN_LEN / `FP_STEP;

	localparam fp_exp_t	EXP_SPECIAL	= fp_exp_t'((1 << `FP_EXP_W) - 1);

	typedef enum logic {st_idle, st_calc} state_t;

	state_t				state;
	logic	[1:0]		counter;
	logic				skip_round;

	fp_man_t			man_b_q;
	logic	[RES_W-1:0]	res_q;
	fp_exp_t			exp_q;
	logic				sign_q;
	logic				invalid_q;
	fp_rm_t				rm_q;

	logic				accept;
	logic				invalid;
	logic				is_nan;
	logic				is_special;
	logic				sign_ab;
	logic	[ACC_W-1:0]	acc;

	assign invalid		= a.snan || b.snan || (a.zero && b.inf) || (a.inf && b.zero);
	assign is_nan		= invalid || a.qnan || b.qnan;
	assign is_special	= is_nan || a.inf || b.inf || a.zero || b.zero;
	assign sign_ab		= a.sign ^ b.sign;

	assign ready_out	= ready_in && state == st_idle;
	assign accept		= valid_in && ready_out;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_out	<= 1'b0;
			skip_round	<= 1'b0;
			counter		<= 2'd0;
			state		<= st_idle;
		end else if (accept) begin
			counter		<= 2'd0;
			skip_round	<= is_special;
			if (is_special) begin
				valid_out	<= 1'b1;	// Special results are ready right away
				state		<= st_idle;
			end else begin
				valid_out	<= 1'b0;
				state		<= st_calc;
			end
		end else begin
			case (state)
				st_idle: begin
					if (valid_out && ready_in)
						valid_out	<= 1'b0;
				end
				st_calc: begin
					if (counter == 2'(STEPS - 1)) begin
						valid_out	<= 1'b1;
						state		<= st_idle;
					end else begin
						counter		<= counter + 2'd1;
					end
				end
				default: state	<= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			rm_q		<= rm;
			invalid_q	<= invalid;
			man_b_q		<= b.man;
			if (is_nan) begin
				// Canonical quiet NaN
				res_q	<= {2'b11, {(RES_W-2){1'b0}}};
				exp_q	<= EXP_SPECIAL;
				sign_q	<= 1'b0;
			end else if (a.inf || b.inf) begin
				res_q	<= {1'b1, {(RES_W-1){1'b0}}};
				exp_q	<= EXP_SPECIAL;
				sign_q	<= sign_ab;
			end else if (a.zero || b.zero) begin
				res_q	<= '0;
				exp_q	<= '0;
				sign_q	<= sign_ab;
			end else begin
				res_q	<= {{MAN_LEN{1'b0}}, a.man};	// Multiplier sits in the low half
				exp_q	<= a.exp + b.exp;
				sign_q	<= sign_ab;
			end
		end else if (state == st_calc) begin
			res_q	<= {acc, res_q[MAN_LEN-1:`FP_STEP]};
		end
	end

	// Partial products for the low multiplier bits, added onto the upper half
	always_comb begin
		acc	= {{`FP_STEP{1'b0}}, res_q[RES_W-1:MAN_LEN]};
		for (int i = 0; i < `FP_STEP; i++) begin
			if (res_q[i])
				acc	= acc + (ACC_W'(man_b_q) << i);
		end
	end

	always_comb begin
		product.sign		= sign_q;
		product.skip_round	= skip_round;
		product.invalid		= invalid_q;
		product.rm			= rm_q;

		if (res_q[RES_W-1] || skip_round) begin
			// Product in [2,4) shifts one place and bumps the exponent
			product.exponent	= exp_q + fp_exp_t'(!skip_round);
			product.mantissa	= res_q[RES_W-1:MAN_LEN];
			product.round_bit	= res_q[MAN_LEN-1];
			product.sticky_bit	= |res_q[MAN_LEN-2:0];
		end else begin
			product.exponent	= exp_q;
			product.mantissa	= res_q[RES_W-2:MAN_LEN-1];
			product.round_bit	= res_q[MAN_LEN-2];
			product.sticky_bit	= |res_q[MAN_LEN-3:0];
		end
	end

endmodule

//--- source/fp_config.svh
`ifndef FP_CONFIG_SVH
`define FP_CONFIG_SVH

// Binary32 field widths
`define FP_EXP_W	8
`define FP_MAN_W	23

// Exponent bias of the format
`define FP_BIAS		127

// Multiplier bits retired per CALC cycle
// Four CALC cycles at 6 bits each cover the whole 24-bit mantissa
`define FP_STEP		6

`endif

//--- source/fp_format_pkg.sv
`include "fp_config.svh"

package fp_format_pkg;

	// Raw binary32 word as it sits in a register
	typedef logic [`FP_EXP_W+`FP_MAN_W:0]	fp_word_t;

	// Mantissa including the hidden bit
	typedef logic [`FP_MAN_W:0]				fp_man_t;

	// Biased exponent with headroom for a sum of two exponents and a negative result
	typedef logic [`FP_EXP_W+1:0]			fp_exp_t;

	typedef struct packed {
		logic		sign;
		fp_exp_t	exp;
		fp_man_t	man;
		logic		zero;		// Zero or flushed subnormal
		logic		inf;
		logic		snan;
		logic		qnan;
	} fp_operand_t;

endpackage

//--- source/fp_mul_unit.sv
`timescale 1ns/1ns

module fp_mul_unit
	import fp_format_pkg::*;
	import fp_round_pkg::*;
(
	input	logic		clk,
	input	logic		reset,

	input	fp_word_t	a,
	input	fp_word_t	b,
	input	fp_rm_t		rm,
	input	logic		valid_in,
	output	logic		ready_out,

	output	fp_word_t	result,
	output	fp_flags_t	flags,
	output	logic		valid_out,
	input	logic		ready_in
);

	fp_operand_t	op_a;
	fp_operand_t	op_b;
	fp_product_t	product;

	fp_unpack unpack_a (
		.word		(a),
		.operand	(op_a)
	);

	fp_unpack unpack_b (
		.word		(b),
		.operand	(op_b)
	);

	// Iterative core, one operation in flight at a time
	float_multiplier mul0 (
		.clk		(clk),
		.reset		(reset),
		.valid_in	(valid_in),
		.ready_out	(ready_out),
		.valid_out	(valid_out),
		.ready_in	(ready_in),
		.rm			(rm),
		.a			(op_a),
		.b			(op_b),
		.product	(product)
	);

	fp_round_pack pack0 (
		.product	(product),
		.result		(result),
		.flags		(flags)
	);

endmodule

//--- source/fp_round_pack.sv
`timescale 1ns/1ns

`include "fp_config.svh"

module fp_round_pack
	import fp_format_pkg::*;
	import fp_round_pkg::*;
(
	input	fp_product_t	product,
	output	fp_word_t		result,
	output	fp_flags_t		flags
);

	localparam fp_exp_t	EXP_ALL_ONES	= fp_exp_t'((1 << `FP_EXP_W) - 1);

	fp_exp_t				exp_unb;
	fp_exp_t				exp_fin;
	logic	[`FP_MAN_W+1:0]	man_sum;
	logic	[`FP_MAN_W-1:0]	frac_fin;
	logic					inc;
	logic					inexact;
	logic					to_inf;

	assign inexact	= product.round_bit || product.sticky_bit;
	assign exp_unb	= product.exponent - fp_exp_t'(`FP_BIAS);

	always_comb begin
		case (product.rm)
			rm_rne: inc	= product.round_bit && (product.sticky_bit || product.mantissa[0]);
			rm_rtz: inc	= 1'b0;
			rm_rdn: inc	= product.sign && inexact;
			rm_rup: inc	= !product.sign && inexact;
			rm_rmm: inc	= product.round_bit;
			default: inc	= 1'b0;
		endcase

		// Overflow goes to infinity unless the mode rounds toward zero for this sign
		case (product.rm)
			rm_rne, rm_rmm: to_inf	= 1'b1;
			rm_rdn: to_inf	= product.sign;
			rm_rup: to_inf	= !product.sign;
			default: to_inf	= 1'b0;
		endcase
	end

	always_comb begin
		man_sum	= {1'b0, product.mantissa} + (`FP_MAN_W+2)'(inc);

		if (man_sum[`FP_MAN_W+1]) begin
			frac_fin	= man_sum[`FP_MAN_W:1];		// Carry out, mantissa back to 1.0
			exp_fin		= exp_unb + fp_exp_t'(1);
		end else begin
			frac_fin	= man_sum[`FP_MAN_W-1:0];
			exp_fin		= exp_unb;
		end
	end

	always_comb begin
		flags			= '0;
		flags.invalid	= product.invalid;

		if (product.skip_round) begin
			result	= {product.sign, product.exponent[`FP_EXP_W-1:0],
				product.mantissa[`FP_MAN_W-1:0]};
		end else if ($signed(exp_fin) >= $signed(EXP_ALL_ONES)) begin
			flags.overflow	= 1'b1;
			flags.inexact	= 1'b1;
			if (to_inf)
				result	= {product.sign, {`FP_EXP_W{1'b1}}, {`FP_MAN_W{1'b0}}};
			else
				result	= {product.sign, {(`FP_EXP_W-1){1'b1}}, 1'b0, {`FP_MAN_W{1'b1}}};
		end else if ($signed(exp_fin) <= 0) begin
			// Below the normal range, flushed to signed zero
			flags.underflow	= 1'b1;
			flags.inexact	= 1'b1;
			result			= {product.sign, {(`FP_EXP_W+`FP_MAN_W){1'b0}}};
		end else begin
			flags.inexact	= inexact;
			result			= {product.sign, exp_fin[`FP_EXP_W-1:0], frac_fin};
		end
	end

endmodule

//--- source/fp_round_pkg.sv
package fp_round_pkg;

	import fp_format_pkg::*;

	typedef enum logic [2:0] {
		rm_rne	= 3'd0,		// Nearest, ties to even
		rm_rtz	= 3'd1,
		rm_rdn	= 3'd2,
		rm_rup	= 3'd3,
		rm_rmm	= 3'd4		// Nearest, ties away from zero
	} fp_rm_t;

	typedef struct packed {
		logic	invalid;
		logic	overflow;
		logic	underflow;
		logic	inexact;
	} fp_flags_t;

	// Unrounded product, exponent is still the sum of both biased exponents
	typedef struct packed {
		logic		sign;
		fp_exp_t	exponent;
		fp_man_t	mantissa;
		logic		round_bit;
		logic		sticky_bit;
		logic		skip_round;		// Special value, pack as is
		logic		invalid;
		fp_rm_t		rm;
	} fp_product_t;

endpackage

//--- source/fp_unpack.sv
`timescale 1ns/1ns

`include "fp_config.svh"

module fp_unpack
	import fp_format_pkg::*;
(
	input	fp_word_t		word,
	output	fp_operand_t	operand
);

	logic	[`FP_EXP_W-1:0]	exp_field;
	logic	[`FP_MAN_W-1:0]	frac;
	logic					exp_ones;

	assign exp_field	= word[`FP_EXP_W+`FP_MAN_W-1:`FP_MAN_W];
	assign frac			= word[`FP_MAN_W-1:0];
	assign exp_ones		= &exp_field;

	always_comb begin
		operand.sign	= word[`FP_EXP_W+`FP_MAN_W];
		operand.exp		= {2'b00, exp_field};

		// A zero exponent field covers subnormals too, they become zero here
		operand.zero	= exp_field == '0;
		operand.inf		= exp_ones && frac == '0;

		// Top fraction bit tells a quiet NaN from a signaling one
		operand.qnan	= exp_ones && frac[`FP_MAN_W-1];
		operand.snan	= exp_ones && frac != '0 && !frac[`FP_MAN_W-1];

		if (operand.zero)
			operand.man	= '0;
		else
			operand.man	= {1'b1, frac};	// Hidden bit restored
	end

endmodule

//--- testbench/fp_mul_unit_tb.sv
`timescale 1ns/1ns

module fp_mul_unit_tb
	import fp_format_pkg::*;
	import fp_round_pkg::*;
();

	localparam int PERIOD = 100;

	// One table row with the expected result and flags
	typedef struct packed {
		fp_word_t	a;
		fp_word_t	b;
		fp_rm_t		rm;
		fp_word_t	result;
		fp_flags_t	flags;
	} vector_t;

	logic		clk;
	logic		reset;
	fp_word_t	a;
	fp_word_t	b;
	fp_rm_t		rm;
	logic		valid_in;
	logic		ready_out;
	fp_word_t	result;
	fp_flags_t	flags;
	logic		valid_out;
	logic		ready_in;

	vector_t	vectors[$];
	string		names[$];
	int			pass_count;
	int			fail_count;
	int			check_errors;
	int			monitor_errors;
	int			results_seen;

	logic [31:0]	lfsr;
	logic			first_bit;
	logic			prev_valid;
	logic			prev_ready;
	fp_word_t		prev_result;
	fp_flags_t		prev_flags;

	fp_mul_unit dut0 (
		.clk		(clk),
		.reset		(reset),
		.a			(a),
		.b			(b),
		.rm			(rm),
		.valid_in	(valid_in),
		.ready_out	(ready_out),
		.result		(result),
		.flags		(flags),
		.valid_out	(valid_out),
		.ready_in	(ready_in)
	);

	initial clk = 1'b0;
	always #(PERIOD/2) clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ 32'h80200003;
		else
			return state >> 1;
	endfunction

	task automatic add_vector(input string name, input fp_word_t x, input fp_word_t y,
		input fp_rm_t mode, input fp_word_t res, input fp_flags_t flg);
		vector_t v;
		v.a			= x;
		v.b			= y;
		v.rm		= mode;
		v.result	= res;
		v.flags		= flg;
		vectors.push_back(v);
		names.push_back(name);
	endtask

	// Flag order is invalid, overflow, underflow, inexact
	task automatic build_table();
		add_vector("exact_1p5_x_2",    32'h3fc00000, 32'h40000000, rm_rne, 32'h40400000, 4'b0000);
		add_vector("exact_neg3_x_half", 32'hc0400000, 32'h3f000000, rm_rne, 32'hbfc00000, 4'b0000);
		add_vector("exact_1p5_x_1p5",  32'h3fc00000, 32'h3fc00000, rm_rne, 32'h40100000, 4'b0000);
		add_vector("tie_rne_odd",      32'h3f800001, 32'h3fc00000, rm_rne, 32'h3fc00002, 4'b0001);
		add_vector("tie_rne_even",     32'h3f800800, 32'h3f800800, rm_rne, 32'h3f801000, 4'b0001);
		add_vector("tie_rmm",          32'h3f800800, 32'h3f800800, rm_rmm, 32'h3f801001, 4'b0001);
		add_vector("rs_rne",           32'h3f800801, 32'h3f800800, rm_rne, 32'h3f801002, 4'b0001);
		add_vector("rs_rtz",           32'h3f800801, 32'h3f800800, rm_rtz, 32'h3f801001, 4'b0001);
		add_vector("rs_rup_pos",       32'h3f800801, 32'h3f800800, rm_rup, 32'h3f801002, 4'b0001);
		add_vector("rs_rdn_pos",       32'h3f800801, 32'h3f800800, rm_rdn, 32'h3f801001, 4'b0001);
		add_vector("rs_rdn_neg",       32'hbf800801, 32'h3f800800, rm_rdn, 32'hbf801002, 4'b0001);
		add_vector("rs_rup_neg",       32'hbf800801, 32'h3f800800, rm_rup, 32'hbf801001, 4'b0001);
		add_vector("sticky_hi_rne",    32'h3fffffff, 32'h3f800001, rm_rne, 32'h40000000, 4'b0001);
		add_vector("carry_rne",        32'h3ffffffe, 32'h3f800001, rm_rne, 32'h40000000, 4'b0001);
		add_vector("qnan_a",           32'h7fc00000, 32'h3f800000, rm_rne, 32'h7fc00000, 4'b0000);
		add_vector("snan_b",           32'h3f800000, 32'h7f800001, rm_rne, 32'h7fc00000, 4'b1000);
		add_vector("zero_x_inf",       32'h00000000, 32'h7f800000, rm_rne, 32'h7fc00000, 4'b1000);
		add_vector("inf_x_neg",        32'h7f800000, 32'hc0000000, rm_rne, 32'hff800000, 4'b0000);
		add_vector("zero_x_neg",       32'h00000000, 32'hc0400000, rm_rne, 32'h80000000, 4'b0000);
		add_vector("subnormal_in",     32'h80400000, 32'h40000000, rm_rne, 32'h80000000, 4'b0000);
		add_vector("ovf_rne",          32'h7f000000, 32'h40000000, rm_rne, 32'h7f800000, 4'b0101);
		add_vector("ovf_rup_neg",      32'hff000000, 32'h40000000, rm_rup, 32'hff7fffff, 4'b0101);
		add_vector("ovf_rdn_neg",      32'hff000000, 32'h40000000, rm_rdn, 32'hff800000, 4'b0101);
		add_vector("unf_rne",          32'h00800000, 32'h3f000000, rm_rne, 32'h00000000, 4'b0011);
		add_vector("unf_neg",          32'h80800000, 32'h3f000000, rm_rtz, 32'h80000000, 4'b0011);
	endtask

	// Presents one row, waits for acceptance, then for the result
	task automatic run_vector(input int i);
		vector_t	v;
		logic		ok;
		v	= vectors[i];
		ok	= 1'b1;
		@(posedge clk);
		a			<= v.a;
		b			<= v.b;
		rm			<= v.rm;
		valid_in	<= 1'b1;
		@(negedge clk);
		while (!(valid_in && ready_out))
			@(negedge clk);
		@(posedge clk);
		valid_in	<= 1'b0;
		@(negedge clk);
		while (!(valid_out && ready_in))
			@(negedge clk);
		if (result !== v.result) begin
			$display("MISMATCH %s result expected %h actual %h", names[i], v.result, result);
			ok	= 1'b0;
		end
		if (flags !== v.flags) begin
			$display("MISMATCH %s flags expected %b actual %b", names[i], v.flags, flags);
			ok	= 1'b0;
		end
		if (ok) begin
			pass_count++;
			$display("ok      %s", names[i]);
		end else begin
			fail_count++;
			$display("failed  %s", names[i]);
		end
	endtask

	// Random back-pressure drops ready_in when both taken bits are set
	initial begin
		lfsr		= 32'h47a8;
		ready_in	<= 1'b1;
		forever begin
			@(posedge clk);
			if (reset) begin
				ready_in	<= 1'b1;
			end else begin
				lfsr		= lfsr_step(lfsr);
				first_bit	= lfsr[0];
				lfsr		= lfsr_step(lfsr);
				ready_in	<= !(first_bit && lfsr[0]);
			end
		end
	end

	always @(negedge clk) begin
		if (!reset) begin
			if (prev_valid && !prev_ready) begin
				if (!valid_out) begin
					$display("valid_out fell while ready_in was low");
					monitor_errors++;
				end else if (result !== prev_result || flags !== prev_flags) begin
					$display("Held result changed while ready_in was low");
					monitor_errors++;
				end
			end
			if (valid_out && !ready_in && ready_out) begin
				$display("ready_out was high while a result waited with ready_in low");
				monitor_errors++;
			end
			if (valid_out && ready_in)
				results_seen++;		// Every consumed result, wanted or not
		end
		prev_valid	= valid_out;
		prev_ready	= ready_in;
		prev_result	= result;
		prev_flags	= flags;
	end

	initial begin
		@(negedge reset);
		repeat (vectors.size() * 40) @(posedge clk);
		$display("Timeout, the DUT stopped answering before all tests finished");
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		reset		<= 1'b1;
		valid_in	<= 1'b0;
		a			<= '0;
		b			<= '0;
		rm			<= rm_rne;
		build_table();
		repeat (4) @(posedge clk);
		reset	<= 1'b0;
		@(negedge clk);
		if (valid_out !== 1'b0 || ready_out !== ready_in) begin
			$display("After reset valid_out is not low or ready_out does not follow ready_in");
			check_errors++;
		end
		for (int i = 0; i < vectors.size(); i++)
			run_vector(i);
		repeat (8) @(posedge clk);
		if (results_seen != vectors.size()) begin
			$display("Expected %0d results but saw %0d", vectors.size(), results_seen);
			check_errors++;
		end
		$display("tests %0d  passed %0d  failed %0d  other errors %0d", vectors.size(),
			pass_count, fail_count, check_errors + monitor_errors);
		if (fail_count + check_errors + monitor_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule
